//--- Makefile
# Verilator build and run of the afe dac chain testbench

VERILATOR ?= verilator
TOP       ?= afe_dac_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= TEST PASS

.PHONY: sim clean

# build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- afe_dac_frame_seq/afe_dac_frame_seq.sv
`timescale 1ns/1ps

// =========================================================================
// frame sequencer: walks the 11 frame order, builds frames, spends credits
// =========================================================================
module afe_dac_frame_seq (
    input  logic                   slow_clk,
    input  logic                   resetS,
    input  logic                   start_req,
    input  afe_dac_pkg::dac_word_t cfg_regs [afe_dac_pkg::NUM_CFG_REGS],
    output afe_dac_pkg::frame_t    frame,          // built frame, held till sent
    output logic                   frame_valid,    // one cycle, spends the credit
    input  logic                   credit_return,  // shifter done with a frame
    output logic                   seq_idle,
    output logic                   busy
);

    localparam afe_dac_pkg::frame_idx_t LAST_FRAME =
        afe_dac_pkg::frame_idx_t'(afe_dac_pkg::NUM_FRAMES - 1);

    afe_dac_pkg::seq_state_e  state;
    afe_dac_pkg::frame_idx_t  frame_idx;     // frame being built / sent
    logic [1:0]               credit_cnt;    // 0 or 1, wider so overflow shows
    int                       field_sel;     // field for current frame
    afe_dac_pkg::bit_cnt_t    len_sel;
    afe_dac_pkg::frame_word_t build_word;

    // =====================================================================
    // frame assembly from the order and length tables
    // =====================================================================
    always_comb
    begin
        field_sel = afe_dac_pkg::frame_field_table[0];
        len_sel   = afe_dac_pkg::frame_len_table[0];
        if (frame_idx <= LAST_FRAME)
        begin
            field_sel = afe_dac_pkg::frame_field_table[frame_idx];
            len_sel   = afe_dac_pkg::frame_len_table[frame_idx];
        end
        // dac 0 word goes in the top slice, shifted out first
        for (int d = 0; d < afe_dac_pkg::NUM_DACS; d++)
        begin
            build_word[(afe_dac_pkg::NUM_DACS-1-d)*afe_dac_pkg::DAC_WORD_W +:
                       afe_dac_pkg::DAC_WORD_W] =
                cfg_regs[field_sel*afe_dac_pkg::NUM_DACS + d];
        end
    end

    // payload only, captured in BUILD
    always_ff @(posedge slow_clk)
    begin
        if (state == afe_dac_pkg::BUILD)
        begin
            frame.data <= build_word;
            frame.len  <= len_sel;
        end
    end

    // hand over only while holding the credit
    assign frame_valid = (state == afe_dac_pkg::SEND) && (credit_cnt != 2'd0);
    assign seq_idle    = (state == afe_dac_pkg::IDLE);
    assign busy        = !seq_idle;

    // =====================================================================
    // credit counter
    // =====================================================================
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            credit_cnt <= 2'd1;                  // shifter starts empty
        end
        else
        begin
            case ({credit_return, frame_valid})
                2'b10:   credit_cnt <= credit_cnt + 2'd1;
                2'b01:   credit_cnt <= credit_cnt - 2'd1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // =====================================================================
    // sequence fsm
    // =====================================================================
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            state     <= afe_dac_pkg::IDLE;
            frame_idx <= '0;
        end
        else
        begin
            case (state)
                afe_dac_pkg::IDLE:
                begin
                    if (start_req)
                    begin
                        frame_idx <= '0;
                        state     <= afe_dac_pkg::BUILD;
                    end
                end
                afe_dac_pkg::BUILD: state <= afe_dac_pkg::SEND;   // one cycle build
                afe_dac_pkg::SEND:
                begin
                    if (frame_valid)
                    begin
                        if (frame_idx == LAST_FRAME)
                            state <= afe_dac_pkg::DONE;
                        else
                        begin
                            frame_idx <= frame_idx + 4'd1;
                            state     <= afe_dac_pkg::BUILD;       // next while this shifts
                        end
                    end
                end
                afe_dac_pkg::DONE:
                begin
                    if (credit_return)
                        state <= afe_dac_pkg::IDLE;            // last frame fully out
                end
                default: state <= afe_dac_pkg::IDLE;
            endcase
        end
    end

endmodule

//--- afe_dac_shifter/afe_dac_shifter.sv
`timescale 1ns/1ps

// =========================================================================
// serial shifter: holding reg, 96 bit shift reg, sync_n framing
// =========================================================================
module afe_dac_shifter (
    input  logic                slow_clk,
    input  logic                resetS,
    input  afe_dac_pkg::frame_t frame,
    input  logic                frame_valid,     // only sent against a credit
    output logic                credit_return,   // one cycle, frame finished
    output logic                sdi,
    output logic                sync_n
);

    afe_dac_pkg::frame_t      hold_frame;    // accepted, not yet shifting
    logic                     hold_valid;
    afe_dac_pkg::frame_word_t sreg;          // msb is on the wire
    afe_dac_pkg::bit_cnt_t    bit_cnt;       // bits left incl. current one
    logic                     load_sreg;     // start a frame this edge
    logic                     last_bit;

    // only start between frames, sync_n must see a high cycle first
    assign load_sreg = sync_n && hold_valid;
    assign last_bit  = !sync_n && (bit_cnt == afe_dac_pkg::bit_cnt_t'(1));
    assign sdi       = sreg[afe_dac_pkg::FRAME_W-1];

    // =====================================================================
    // holding register
    // =====================================================================
    always_ff @(posedge slow_clk)
    begin
        if (frame_valid)
        begin
            hold_frame <= frame;
        end
    end

    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            hold_valid <= 1'b0;
        end
        else if (frame_valid)
        begin
            hold_valid <= 1'b1;
        end
        else if (load_sreg)
        begin
            hold_valid <= 1'b0;      // drained into sreg
        end
    end

    // =====================================================================
    // shift register, msb first
    // =====================================================================
    always_ff @(posedge slow_clk)
    begin
        if (load_sreg)
        begin
            sreg <= hold_frame.data;
        end
        else if (!sync_n)
        begin
            sreg <= {sreg[afe_dac_pkg::FRAME_W-2:0], 1'b0};
        end
    end

    // =====================================================================
    // bit counter, sync_n and credit return
    // =====================================================================
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            sync_n        <= 1'b1;
            bit_cnt       <= '0;
            credit_return <= 1'b0;
        end
        else
        begin
            credit_return <= 1'b0;
            if (load_sreg)
            begin
                sync_n  <= 1'b0;             // low for exactly len cycles
                bit_cnt <= hold_frame.len;
            end
            else if (last_bit)
            begin
                // holding reg already empty, it drained at frame start
                sync_n        <= 1'b1;
                credit_return <= 1'b1;
            end
            else if (!sync_n)
            begin
                bit_cnt <= bit_cnt - afe_dac_pkg::bit_cnt_t'(1);
            end
        end
    end

endmodule

//--- common/afe_dac_pkg.sv
// =========================================================================
// shared types, register map and frame tables for the afe dac chain
// =========================================================================
package afe_dac_pkg;

    localparam int DAC_WORD_W   = 32;          // one dac shift word
    localparam int NUM_DACS     = 3;           // dacs in the daisy chain
    localparam int FRAME_W      = DAC_WORD_W * NUM_DACS;
    localparam int NUM_FIELDS   = 7;           // mode, ldac, dcen, cha..chd
    localparam int NUM_CFG_REGS = NUM_FIELDS * NUM_DACS;
    localparam int NUM_FRAMES   = 11;          // frames per config sequence
    localparam int CTRL_ADDR    = 26;          // control reg, bit 0 = start

    typedef logic [DAC_WORD_W-1:0] dac_word_t;
    typedef logic [FRAME_W-1:0]    frame_word_t; // first dac word on top
    typedef logic [4:0]            reg_addr_t;
    typedef logic [6:0]            bit_cnt_t;    // up to 96 bits per frame
    typedef logic [3:0]            frame_idx_t;  // 0..10

    // field numbers, register address = field * NUM_DACS + dac index
    localparam int FIELD_MODE = 0;
    localparam int FIELD_LDAC = 1;   // \LDAC mask
    localparam int FIELD_DCEN = 2;   // daisy chain enable
    localparam int FIELD_CHA  = 3;
    localparam int FIELD_CHB  = 4;
    localparam int FIELD_CHC  = 5;
    localparam int FIELD_CHD  = 6;

    // power-on contents of the 21 config regs, in address order
    localparam dac_word_t cfg_default_table [NUM_CFG_REGS] = '{
        32'h0040_0000, 32'h0040_0000, 32'h0040_0000,  // mode, all channels on
        32'h00b0_000f, 32'h00b0_000f, 32'h00b0_000f,  // \LDAC, no channel held
        32'h0080_0001, 32'h0080_0001, 32'h0080_0001,  // dcen set
        32'h0030_8000, 32'h0030_8100, 32'h0030_8200,  // ch a near mid scale
        32'h0031_8000, 32'h0031_8100, 32'h0031_8200,  // ch b
        32'h0032_8000, 32'h0032_8100, 32'h0032_8200,  // ch c
        32'h0033_8000, 32'h0033_8100, 32'h0033_8200   // ch d
    };

    // field sent in each frame of a sequence
    // chain is opened one dac at a time through ldac/dcen, then full writes
    localparam int frame_field_table [NUM_FRAMES] = '{
        FIELD_LDAC, FIELD_DCEN,     // first dac only
        FIELD_LDAC, FIELD_DCEN,     // first two dacs
        FIELD_LDAC, FIELD_DCEN,     // whole chain
        FIELD_MODE,
        FIELD_CHA, FIELD_CHB, FIELD_CHC, FIELD_CHD
    };

    // bits shifted per frame, always the top bits of the frame word
    localparam bit_cnt_t frame_len_table [NUM_FRAMES] = '{
        7'd32, 7'd32,
        7'd64, 7'd64,
        7'd96, 7'd96, 7'd96, 7'd96, 7'd96, 7'd96, 7'd96
    };

    // one host bus write
    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        dac_word_t data;
    } bus_wr_t;

    // one assembled chain frame
    typedef struct packed {
        frame_word_t data;
        bit_cnt_t    len;
    } frame_t;

    typedef enum logic [1:0] {
        IDLE,    // waiting for start
        BUILD,   // assembling frame from cfg regs
        SEND,    // holding frame until a credit is available
        DONE     // last frame out, waiting for its credit
    } seq_state_e;

endpackage

//--- hdl/afe_dac_regbank.sv
`timescale 1ns/1ps

// =========================================================================
// host register bank: 21 dac config words and the control register
// =========================================================================
module afe_dac_regbank (
    input  logic                   slow_clk,
    input  logic                   resetS,
    input  afe_dac_pkg::bus_wr_t   bus_wr,      // one write per cycle max
    input  logic                   seq_idle,    // sequencer can take a start
    output afe_dac_pkg::dac_word_t cfg_regs [afe_dac_pkg::NUM_CFG_REGS],
    output logic                   start_req    // one cycle start pulse
);

    logic cfg_wr;        // write hits a config register
    logic ctrl_wr;       // write hits the control register
    logic ctrl_start;    // control bit 0, other control bits not implemented
    logic start_edge;    // bit 0 going 0 -> 1 on this write

    // =====================================================================
    // address decode
    // =====================================================================
    // addresses 21..25 and 27..31 fall through both compares and are dropped
    assign cfg_wr  = bus_wr.valid &&
                     (bus_wr.addr < afe_dac_pkg::reg_addr_t'(afe_dac_pkg::NUM_CFG_REGS));
    assign ctrl_wr = bus_wr.valid &&
                     (bus_wr.addr == afe_dac_pkg::reg_addr_t'(afe_dac_pkg::CTRL_ADDR));

    // rising edge seen from the write itself, so the pulse lands
    // exactly one cycle after the control write
    assign start_edge = ctrl_wr && bus_wr.data[0] && !ctrl_start;

    // =====================================================================
    // configuration registers
    // =====================================================================
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            cfg_regs <= afe_dac_pkg::cfg_default_table;    // back to defaults
        end
        else if (cfg_wr)
        begin
            cfg_regs[bus_wr.addr] <= bus_wr.data;
        end
    end

    // =====================================================================
    // control register and start pulse
    // =====================================================================
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            ctrl_start <= 1'b0;
            start_req  <= 1'b0;
        end
        else
        begin
            if (ctrl_wr)
            begin
                ctrl_start <= bus_wr.data[0];
            end
            // a start while a sequence runs is simply lost
            start_req <= start_edge && seq_idle;
        end
    end

endmodule

//--- hdl/afe_dac_top.sv
`timescale 1ns/1ps

// =========================================================================
// afe dac chain configuration: regbank -> frame sequencer -> shifter
// =========================================================================
module afe_dac_top (
    input  logic                 slow_clk,
    input  logic                 resetS,
    input  afe_dac_pkg::bus_wr_t bus_wr,   // host writes
    output logic                 busy,     // sequence running
    output logic                 sclk,     // serial clock to the dacs
    output logic                 sdi,      // serial data, msb first
    output logic                 sync_n    // frame enable, active low
);

    afe_dac_pkg::dac_word_t cfg_regs [afe_dac_pkg::NUM_CFG_REGS];
    afe_dac_pkg::frame_t    frame;
    logic                   start_req;
    logic                   seq_idle;
    logic                   frame_valid;
    logic                   credit_return;

    // dacs latch sdi on the falling edge of slow_clk
    assign sclk = ~slow_clk;

    afe_dac_regbank afe_dac_regbank_inst (
        .slow_clk  (slow_clk),
        .resetS    (resetS),
        .bus_wr    (bus_wr),
        .seq_idle  (seq_idle),
        .cfg_regs  (cfg_regs),
        .start_req (start_req)
    );

    afe_dac_frame_seq afe_dac_frame_seq_inst (
        .slow_clk      (slow_clk),
        .resetS        (resetS),
        .start_req     (start_req),
        .cfg_regs      (cfg_regs),
        .frame         (frame),
        .frame_valid   (frame_valid),
        .credit_return (credit_return),
        .seq_idle      (seq_idle),
        .busy          (busy)
    );

    afe_dac_shifter afe_dac_shifter_inst (
        .slow_clk      (slow_clk),
        .resetS        (resetS),
        .frame         (frame),
        .frame_valid   (frame_valid),
        .credit_return (credit_return),
        .sdi           (sdi),
        .sync_n        (sync_n)
    );

endmodule

//--- verif/afe_dac_chk.sv
`timescale 1ns/1ps

// =========================================================================
// credit and framing assertions for the sequencer and the shifter
// =========================================================================
module afe_dac_chk (
    input logic                  slow_clk,
    input logic                  resetS,
    input logic [1:0]            credit_cnt,
    input logic                  frame_valid,
    input logic                  hold_valid,   // shifter holding reg occupied
    input logic                  load_sreg,    // frame moves into the shift reg
    input afe_dac_pkg::bit_cnt_t load_len,
    input logic                  sync_n
);

    afe_dac_pkg::bit_cnt_t exp_len;      // len of the frame on the wire
    afe_dac_pkg::bit_cnt_t low_cnt;      // sync_n low cycles so far
    logic                  sync_n_q;

    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            exp_len  <= '0;
            low_cnt  <= '0;
            sync_n_q <= 1'b1;
        end
        else
        begin
            sync_n_q <= sync_n;
            if (load_sreg)
                exp_len <= load_len;
            low_cnt <= sync_n ? '0 : low_cnt + afe_dac_pkg::bit_cnt_t'(1);
        end
    end

    credit_max: assert property (@(posedge slow_clk) disable iff (resetS)
        credit_cnt <= 2'd1)
        else $error("credit counter above one");

    // the credit stands for an empty holding reg between two frames
    valid_needs_credit: assert property (@(posedge slow_clk) disable iff (resetS)
        frame_valid |-> sync_n && !hold_valid)
        else $error("frame_valid raised without a credit");

    // count stays below len while the frame runs
    low_in_frame: assert property (@(posedge slow_clk) disable iff (resetS)
        !sync_n |-> low_cnt < exp_len)
        else $error("sync_n held low past the frame length");

    low_exact: assert property (@(posedge slow_clk) disable iff (resetS)
        (sync_n && !sync_n_q) |-> low_cnt == exp_len)
        else $error("sync_n low cycles differ from the frame length");

endmodule

// credit counter of the sequencer
bind afe_dac_frame_seq afe_dac_chk afe_dac_chk_seq_inst (
    .slow_clk    (slow_clk),
    .resetS      (resetS),
    .credit_cnt  (credit_cnt),
    .frame_valid (frame_valid),
    .hold_valid  (1'b0),
    .load_sreg   (1'b0),
    .load_len    (afe_dac_pkg::bit_cnt_t'(0)),
    .sync_n      (1'b1)
);

// frame acceptance and framing in the shifter
bind afe_dac_shifter afe_dac_chk afe_dac_chk_shift_inst (
    .slow_clk    (slow_clk),
    .resetS      (resetS),
    .credit_cnt  (2'd1),
    .frame_valid (frame_valid),
    .hold_valid  (hold_valid),
    .load_sreg   (load_sreg),
    .load_len    (hold_frame.len),
    .sync_n      (sync_n)
);

//--- verif/afe_dac_clk_gen.sv
`timescale 1ns/1ps

// testbench clock and power-on reset
module afe_dac_clk_gen (
    output logic slow_clk,
    output logic resetS
);

    localparam int HALF_PERIOD_NS = 50;    // 100 ns period
    localparam int RESET_CYCLES   = 16;

    initial
    begin
        slow_clk = 1'b0;
        forever #HALF_PERIOD_NS slow_clk = ~slow_clk;
    end

    // release lands 1 ns after an edge, same as the other inputs
    initial
    begin
        resetS = 1'b1;
        repeat (RESET_CYCLES) @(posedge slow_clk);
        #1 resetS = 1'b0;
    end

endmodule

//--- verif/afe_dac_tb.sv
`timescale 1ns/1ps

// =========================================================================
// testbench for the afe dac chain configuration top
// =========================================================================
module afe_dac_tb;

    localparam int NUM_REGS      = 21;     // 7 fields x 3 dacs
    localparam int CTRL          = 26;     // control reg with the start in bit 0
    localparam int UNMAPPED      = 30;
    localparam int SEQ_FRAMES    = 11;
    localparam int START_TIMEOUT = 10;     // cycles from write to busy
    localparam int SEQ_TIMEOUT   = 3000;   // whole sequence
    localparam int FRAME_TIMEOUT = 400;    // until a given frame is on the wire
    localparam int QUIET_CYCLES  = 150;
    localparam int IDLE_CYCLES   = 200;

    // ldac and dcen open the chain one dac at a time before mode and cha..chd
    localparam int frame_field [SEQ_FRAMES] = '{1, 2, 1, 2, 1, 2, 0, 3, 4, 5, 6};
    localparam int frame_len [SEQ_FRAMES]   = '{32, 32, 64, 64, 96, 96, 96, 96, 96, 96, 96};

    typedef struct packed {
        logic [4:0]  addr;
        logic [31:0] data;
        logic        expect_start;
        logic        at_frame_en;   // hold the write until at_frame is shifting
        logic [3:0]  at_frame;
    } stim_row_t;

    logic                 slow_clk;
    logic                 resetS;
    afe_dac_pkg::bus_wr_t bus_wr;
    logic                 busy;
    logic                 sclk;
    logic                 sdi;
    logic                 sync_n;

    stim_row_t   stim_table [$];
    logic [31:0] model_regs [NUM_REGS];    // what the dut regs should hold
    logic [31:0] seq_regs [NUM_REGS];      // snapshot taken at start
    logic [95:0] cap_data [$];             // captured frames aligned to the lsb
    int          cap_len [$];
    int          frames_started;
    int          error_cnt;
    int          pass_cnt;
    int          fail_cnt;
    integer      seed;

    afe_dac_clk_gen afe_dac_clk_gen_inst (
        .slow_clk (slow_clk),
        .resetS   (resetS)
    );

    afe_dac_top afe_dac_top_inst (
        .slow_clk (slow_clk),
        .resetS   (resetS),
        .bus_wr   (bus_wr),
        .busy     (busy),
        .sclk     (sclk),
        .sdi      (sdi),
        .sync_n   (sync_n)
    );

    // =====================================================================
    // serial capture of sdi on falling slow_clk
    // =====================================================================
    task automatic capture_frames();
        logic [95:0] shift_bits;
        int          nbits;
        logic        in_frame;
        shift_bits = '0;
        nbits      = 0;
        in_frame   = 1'b0;
        forever
        begin
            @(negedge slow_clk);
            if (!resetS && sync_n === 1'b0)
            begin
                if (!in_frame)
                    frames_started++;
                in_frame   = 1'b1;
                shift_bits = {shift_bits[94:0], sdi};    // msb arrives first
                nbits++;
            end
            else if (in_frame)
            begin
                cap_data.push_back(shift_bits);          // sync_n rose so the frame is done
                cap_len.push_back(nbits);
                shift_bits = '0;
                nbits      = 0;
                in_frame   = 1'b0;
            end
        end
    endtask

    initial
        capture_frames();

    // =====================================================================
    // bus driving and waits
    // =====================================================================
    task automatic drive_write(input logic [4:0] addr, input logic [31:0] data);
        @(posedge slow_clk);
        #1;
        bus_wr.valid = 1'b1;
        bus_wr.addr  = addr;
        bus_wr.data  = data;
        @(posedge slow_clk);
        #1;
        bus_wr = '0;
        if (int'(addr) < NUM_REGS)
            model_regs[addr] = data;                     // unmapped writes change nothing
    endtask

    task automatic wait_busy(input logic level, input int limit, input string what);
        bit seen;
        int n;
        seen = 1'b0;
        for (n = 0; n < limit && !seen; n++)
        begin
            @(negedge slow_clk);
            if (busy === level)
                seen = 1'b1;
        end
        if (!seen)
        begin
            $display("timeout: busy did not %s within %0d cycles", what, limit);
            error_cnt++;
        end
    endtask

    // waits until frame number target-1 of the sequence is shifting
    task automatic wait_frame(input int target);
        bit seen;
        int n;
        seen = 1'b0;
        for (n = 0; n < FRAME_TIMEOUT && !seen; n++)
        begin
            @(negedge slow_clk);
            #1;                                          // after the capture update
            if (frames_started >= target && sync_n === 1'b0)
                seen = 1'b1;
        end
        if (!seen)
        begin
            $display("timeout: frame %0d never appeared on the serial port", target - 1);
            error_cnt++;
        end
    endtask

    task automatic wait_reset_release();
        int n;
        for (n = 0; n < 40 && resetS !== 1'b0; n++)
            @(posedge slow_clk);
        if (resetS !== 1'b0)
        begin
            $display("timeout: reset was never released");
            error_cnt++;
        end
    endtask

    // =====================================================================
    // expected frames and sequence checking
    // =====================================================================
    // first dac word on top and only the top len bits go out
    function automatic logic [95:0] expected_frame(input int idx);
        logic [95:0] chain;
        int          f;
        f     = frame_field[idx];
        chain = {seq_regs[f*3], seq_regs[f*3+1], seq_regs[f*3+2]};
        return chain >> (96 - frame_len[idx]);
    endfunction

    task automatic finish_sequence(input int seq_base);
        int n;
        int nframes;
        bit quiet;
        quiet = 1'b1;
        wait_busy(1'b0, SEQ_TIMEOUT, "fall at the end of the sequence");
        for (n = 0; n < QUIET_CYCLES; n++)
        begin
            @(negedge slow_clk);
            if (sync_n !== 1'b1)
                quiet = 1'b0;
        end
        if (!quiet)
        begin
            $display("[FAIL] sync_n after busy fell: expected 0x1 got 0x0");
            error_cnt++;
        end
        nframes = cap_data.size() - seq_base;
        if (nframes != SEQ_FRAMES)
        begin
            $display("[FAIL] frame count: expected 0x%0h got 0x%0h", SEQ_FRAMES, nframes);
            error_cnt++;
        end
        for (n = 0; n < nframes && n < SEQ_FRAMES; n++)
        begin
            if (cap_len[seq_base+n] != frame_len[n])
            begin
                $display("[FAIL] frame %0d sync_n low cycles: expected 0x%0h got 0x%0h",
                         n, frame_len[n], cap_len[seq_base+n]);
                error_cnt++;
            end
            else if (cap_data[seq_base+n] !== expected_frame(n))
            begin
                $display("[FAIL] frame %0d sdi: expected 0x%h got 0x%h",
                         n, expected_frame(n), cap_data[seq_base+n]);
                error_cnt++;
            end
        end
    endtask

    // =====================================================================
    // stimulus table
    // =====================================================================
    task automatic add_row(input logic [4:0] addr, input logic [31:0] data,
                           input logic expect_start, input logic at_frame_en,
                           input logic [3:0] at_frame);
        stim_table.push_back({addr, data, expect_start, at_frame_en, at_frame});
    endtask

    task automatic run_table();
        stim_row_t row;
        bit        pending;     // a started sequence still to be checked
        int        seq_base;
        int        start_count;
        int        r;
        pending     = 1'b0;
        seq_base    = 0;
        start_count = 0;
        for (r = 0; r < stim_table.size(); r++)
        begin
            row = stim_table[r];
            if (row.expect_start && pending)
            begin
                finish_sequence(seq_base);
                pending = 1'b0;
            end
            if (row.at_frame_en)
                wait_frame(start_count + int'(row.at_frame) + 1);
            drive_write(row.addr, row.data);
            if (row.expect_start)
            begin
                seq_regs    = model_regs;
                seq_base    = cap_data.size();
                start_count = frames_started;
                wait_busy(1'b1, START_TIMEOUT, "rise after the start write");
                pending     = 1'b1;
            end
        end
        if (pending)
            finish_sequence(seq_base);
        stim_table.delete();
    endtask

    task automatic check_idle();
        int n;
        bit bad;
        bad = 1'b0;
        for (n = 0; n < IDLE_CYCLES && !bad; n++)
        begin
            @(negedge slow_clk);
            #1;
            if (sync_n !== 1'b1)
            begin
                $display("[FAIL] sync_n while idle: expected 0x1 got 0x%h", sync_n);
                bad = 1'b1;
            end
            if (busy !== 1'b0)
            begin
                $display("[FAIL] busy while idle: expected 0x0 got 0x%h", busy);
                bad = 1'b1;
            end
            if (sclk !== 1'b1)
            begin
                $display("[FAIL] sclk with slow_clk low: expected 0x1 got 0x%h", sclk);
                bad = 1'b1;
            end
            @(posedge slow_clk);
            #1;
            if (sclk !== 1'b0)
            begin
                $display("[FAIL] sclk with slow_clk high: expected 0x0 got 0x%h", sclk);
                bad = 1'b1;
            end
        end
        if (cap_data.size() != 0)
        begin
            $display("[FAIL] frame count: expected 0x0 got 0x%0h", cap_data.size());
            bad = 1'b1;
        end
        if (bad)
            error_cnt++;
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        if (error_cnt == errs_before)
        begin
            pass_cnt++;
            $display("test %0d %s: ok", num, name);
        end
        else
        begin
            fail_cnt++;
            $display("test %0d %s: %0d errors", num, name, error_cnt - errs_before);
        end
    endtask

    // =====================================================================
    // test sequence
    // =====================================================================
    initial
    begin
        int i;
        int errs;
        bus_wr         = '0;
        seed           = 32'hbaec_1177;
        frames_started = 0;
        error_cnt      = 0;
        pass_cnt       = 0;
        fail_cnt       = 0;
        for (i = 0; i < NUM_REGS; i++)
            model_regs[i] = afe_dac_pkg::cfg_default_table[i];   // reset contents
        wait_reset_release();

        errs = error_cnt;
        check_idle();
        report_test(1, "idle after reset", errs);

        errs = error_cnt;
        add_row(5'(CTRL), 32'h1, 1'b1, 1'b0, 4'd0);
        run_table();
        report_test(2, "default configuration", errs);

        errs = error_cnt;
        for (i = 0; i < NUM_REGS; i++)
            add_row(5'(i), $random(seed), 1'b0, 1'b0, 4'd0);
        add_row(5'(CTRL), 32'h0, 1'b0, 1'b0, 4'd0);      // bit 0 back low for a new edge
        add_row(5'(CTRL), 32'h1, 1'b1, 1'b0, 4'd0);
        run_table();
        report_test(3, "random configuration", errs);

        // second start lands while frame 3 shifts and has to be dropped
        errs = error_cnt;
        add_row(5'(CTRL), 32'h0, 1'b0, 1'b0, 4'd0);
        add_row(5'(CTRL), 32'h1, 1'b1, 1'b0, 4'd0);
        add_row(5'(CTRL), 32'h0, 1'b0, 1'b1, 4'd3);
        add_row(5'(CTRL), 32'h1, 1'b0, 1'b1, 4'd3);
        add_row(5'(CTRL), 32'h0, 1'b0, 1'b0, 4'd0);
        add_row(5'(CTRL), 32'h1, 1'b1, 1'b0, 4'd0);
        run_table();
        report_test(4, "start while busy", errs);

        errs = error_cnt;
        add_row(5'(UNMAPPED), $random(seed), 1'b0, 1'b0, 4'd0);
        add_row(5'(CTRL), 32'h0, 1'b0, 1'b0, 4'd0);
        add_row(5'(CTRL), 32'h1, 1'b1, 1'b0, 4'd0);
        run_table();
        report_test(5, "unmapped address", errs);

        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && error_cnt == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- vlog.f
common/afe_dac_pkg.sv
hdl/afe_dac_regbank.sv
afe_dac_frame_seq/afe_dac_frame_seq.sv
afe_dac_shifter/afe_dac_shifter.sv
hdl/afe_dac_top.sv
verif/afe_dac_clk_gen.sv
verif/afe_dac_chk.sv
verif/afe_dac_tb.sv
